// ==== hw/sdrx_pkg.sv ====
`default_nettype none

package sdrx_pkg;

	////////////////////////////////////////
	// Block geometry
	////////////////////////////////////////

	// Largest block is 2^LGLEN bytes
	localparam int LGLEN = 9;
	// Data wires, each one a CRC rail
	localparam int NUMIO = 4;

	// External word memory
	localparam int MW     = 32;
	localparam int NLANE  = MW / 8;
	localparam int LGLANE = 2;
	// Word address width
	localparam int LGLENW = LGLEN - LGLANE;

	////////////////////////////////////////
	// Bus width codes
	////////////////////////////////////////

	localparam logic WIDTH_1W = 1'b0;
	localparam logic WIDTH_4W = 1'b1;

	////////////////////////////////////////
	// CRC16, MSB first, zero seed
	////////////////////////////////////////

	localparam int          CRC_W    = 16;
	localparam logic [15:0] CRC_POLY = 16'h1021;

	// Rail-bit counter, up to length*8 data halves plus the check halves
	localparam int CNT_W = LGLEN + 4;

	// Idle watchdog, expires after 2^LGTIMEOUT-1 strobe-free cycles
	localparam int LGTIMEOUT = 10;

	// Sampled wires, upper byte is the older half
	typedef logic [15:0] rxdata_t;
	typedef logic [7:0]  byte_t;

endpackage

`default_nettype wire

// ==== hw/sdrx_phase.sv ====
`default_nettype none

module sdrx_phase import sdrx_pkg::*; (
	input	wire			i_clk,
	input	wire			i_reset,
	input	wire			i_rx_en,
	input	wire			i_cfg_width,
	input	wire	[LGLEN:0]	i_length,
	input	wire	[1:0]		i_rx_strb,
	output	logic			o_data_hi,
	output	logic			o_data_lo,
	output	logic			o_chk_hi,
	output	logic			o_chk_lo,
	output	logic			o_busy,
	output	logic			o_block_end
);

	logic			r_busy;
	// Block finished, wait for the enable to drop
	logic			r_spent;
	logic	[CNT_W-1:0]	r_count;
	logic	[CNT_W-1:0]	load_count;
	logic	[CNT_W-1:0]	cur_count;
	logic	[CNT_W-1:0]	lo_count;
	logic	[CNT_W-1:0]	nxt_count;
	logic			active;
	logic			hi_take;
	logic			lo_take;

	////////////////////////////////////////
	// Half classification
	////////////////////////////////////////

	// Rail bits in a block, data halves then check halves
	always_comb
	begin
		if (i_cfg_width == WIDTH_1W)
			load_count = (CNT_W'(i_length) << 3) + CNT_W'(CRC_W);
		else
			load_count = (CNT_W'(i_length) << 1) + CNT_W'(CRC_W);
	end

	// Idle cycle uses the fresh count so the first strobes are not lost
	assign	active    = i_rx_en && (r_busy || (!r_spent && (i_length != 0)));
	assign	cur_count = r_busy ? r_count : load_count;

	// First half sees the count as it stands
	assign	hi_take   = active && i_rx_strb[1] && (cur_count != 0);
	assign	o_data_hi = hi_take && (cur_count > CNT_W'(CRC_W));
	assign	o_chk_hi  = hi_take && (cur_count <= CNT_W'(CRC_W));

	// Second half sees the count after the first, covers the boundary cycle
	assign	lo_count  = cur_count - CNT_W'(hi_take);
	assign	lo_take   = active && i_rx_strb[0] && (lo_count != 0);
	assign	o_data_lo = lo_take && (lo_count > CNT_W'(CRC_W));
	assign	o_chk_lo  = lo_take && (lo_count <= CNT_W'(CRC_W));

	assign	nxt_count   = lo_count - CNT_W'(lo_take);
	// Last check half consumed this cycle
	assign	o_block_end = (hi_take || lo_take) && (nxt_count == 0);

	assign	o_busy = r_busy;

	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en)
	begin
		r_busy  <= 1'b0;
		r_spent <= 1'b0;
		r_count <= '0;
	end else if (active)
	begin
		r_busy  <= !o_block_end;
		r_spent <= o_block_end;
		r_count <= nxt_count;
	end

	// No data half may follow a check half within a block
	a_chk_after_data: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_chk_hi || o_chk_lo) |=> !(o_data_hi || o_data_lo));

endmodule

`default_nettype wire

// ==== hw/sdrx_bitpack.sv ====
`default_nettype none

module sdrx_bitpack import sdrx_pkg::*; (
	input	wire		i_clk,
	input	wire		i_reset,
	input	wire		i_rx_en,
	input	wire		i_cfg_width,
	input	wire		i_data_hi,
	input	wire		i_data_lo,
	input	rxdata_t	i_rx_data,
	output	logic		o_byte_valid,
	output	byte_t		o_byte
);

	// Bit register, newest bit at bit 0
	logic	[15:0]	r_sreg;
	logic	[15:0]	nxt_sreg;
	// Bits held that have not left as a byte
	logic	[3:0]	r_fill;
	logic	[4:0]	nxt_fill;
	logic	[3:0]	bits_hi;
	logic	[3:0]	bits_lo;
	// Bits per half, 1 or 4
	logic	[2:0]	step;
	logic		full;

	////////////////////////////////////////
	// Bit collection
	////////////////////////////////////////

	always_comb
	begin
		if (i_cfg_width == WIDTH_4W)
		begin
			// Nibble high bit came first on the wire
			bits_hi = i_rx_data[11:8];
			bits_lo = i_rx_data[3:0];
			step    = 3'd4;
		end else begin
			bits_hi = {3'b000, i_rx_data[8]};
			bits_lo = {3'b000, i_rx_data[0]};
			step    = 3'd1;
		end
	end

	// Older half enters the register first
	always_comb
	begin
		nxt_sreg = r_sreg;
		nxt_fill = {1'b0, r_fill};
		if (i_data_hi)
		begin
			nxt_sreg = (nxt_sreg << step) | 16'(bits_hi);
			nxt_fill = nxt_fill + 5'(step);
		end
		if (i_data_lo)
		begin
			nxt_sreg = (nxt_sreg << step) | 16'(bits_lo);
			nxt_fill = nxt_fill + 5'(step);
		end
	end

	// At most eight new bits per cycle, so one byte at most
	assign	full = (nxt_fill >= 5'd8);

	////////////////////////////////////////
	// Byte output
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en)
	begin
		r_fill       <= '0;
		o_byte_valid <= 1'b0;
	end else begin
		o_byte_valid <= full;
		// Remainder stays for the next byte
		r_fill       <= full ? 4'(nxt_fill - 5'd8) : nxt_fill[3:0];
	end

	always_ff @(posedge i_clk)
	begin
		r_sreg <= nxt_sreg;
		if (full)
			// Oldest eight bits sit just above the remainder
			o_byte <= byte_t'(nxt_sreg >> (nxt_fill - 5'd8));
	end

	// Remainder plus one cycle of halves fits the register
	a_fill_bound: assert property (@(posedge i_clk) disable iff (i_reset)
		nxt_fill <= 5'd15);

endmodule

`default_nettype wire

// ==== hw/sdrx_memwrite.sv ====
`default_nettype none

module sdrx_memwrite import sdrx_pkg::*; (
	input	wire			i_clk,
	input	wire			i_reset,
	input	wire			i_rx_en,
	input	wire			i_byte_valid,
	input	byte_t			i_byte,
	output	logic			o_mem_valid,
	output	logic	[NLANE-1:0]	o_mem_strb,
	output	logic	[LGLENW-1:0]	o_mem_addr,
	output	logic	[MW-1:0]	o_mem_data
);

	// Next byte position, word then lane
	logic	[LGLENW-1:0]	r_addr;
	logic	[LGLANE-1:0]	r_lane;
	logic	[NLANE-1:0]	lane_strb;
	logic	[MW-1:0]	lane_data;

	////////////////////////////////////////
	// Lane placement, big endian
	////////////////////////////////////////

	// Lane 0 is the top byte, strobe bit NLANE-1
	assign	lane_strb = {1'b1, {(NLANE-1){1'b0}}} >> r_lane;
	// Other lanes stay zero
	assign	lane_data = {i_byte, {(MW-8){1'b0}}} >> {r_lane, 3'b000};

	// Control side, cleared while disabled
	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en)
	begin
		r_addr      <= '0;
		r_lane      <= '0;
		o_mem_valid <= 1'b0;
		o_mem_strb  <= '0;
	end else begin
		o_mem_valid <= i_byte_valid;
		o_mem_strb  <= i_byte_valid ? lane_strb : '0;
		// Lane carries into the word address
		if (i_byte_valid)
			{r_addr, r_lane} <= {r_addr, r_lane} + (LGLENW+LGLANE)'(1);
	end

	// Write payload
	always_ff @(posedge i_clk)
	if (i_byte_valid)
	begin
		o_mem_addr <= r_addr;
		o_mem_data <= lane_data;
	end

endmodule

`default_nettype wire

// ==== hw/sdrx_crcrail.sv ====
`default_nettype none

module sdrx_crcrail import sdrx_pkg::*; (
	input	wire			i_clk,
	input	wire			i_reset,
	input	wire			i_rx_en,
	input	wire			i_crc_en,
	input	wire			i_cfg_width,
	input	wire			i_data_hi,
	input	wire			i_data_lo,
	input	wire			i_chk_hi,
	input	wire			i_chk_lo,
	input	wire			i_block_end,
	input	rxdata_t		i_rx_data,
	output	logic			o_crc_valid,
	output	wire	[NUMIO-1:0]	o_crc_bad
);

	// One serial CRC step, MSB first
	function automatic logic [CRC_W-1:0] crc_step(input logic [CRC_W-1:0] prior,
			input logic bit_in);
		logic	[CRC_W-1:0]	shifted;
		shifted = {prior[CRC_W-2:0], 1'b0};
		if (prior[CRC_W-1] ^ bit_in)
			return shifted ^ CRC_POLY;
		return shifted;
	endfunction

	////////////////////////////////////////
	// Per-rail CRC and check bits
	////////////////////////////////////////

	for (genvar gk = 0; gk < NUMIO; gk++)
	begin : g_rail
		logic	[CRC_W-1:0]	r_crc, nxt_crc;
		logic	[CRC_W-1:0]	r_chk, nxt_chk;
		logic			rail_on;
		logic			r_bad;

		// Only rail 0 carries data on a single wire
		assign	rail_on = (gk == 0) || (i_cfg_width == WIDTH_4W);

		// Older half steps first
		always_comb
		begin
			nxt_crc = r_crc;
			nxt_chk = r_chk;
			if (i_data_hi)
				nxt_crc = crc_step(nxt_crc, i_rx_data[8+gk]);
			if (i_data_lo)
				nxt_crc = crc_step(nxt_crc, i_rx_data[gk]);
			if (i_chk_hi)
				nxt_chk = {nxt_chk[CRC_W-2:0], i_rx_data[8+gk]};
			if (i_chk_lo)
				nxt_chk = {nxt_chk[CRC_W-2:0], i_rx_data[gk]};
		end

		// Seed is zero, held there while checking is off
		always_ff @(posedge i_clk)
		if (i_reset || !i_rx_en || !i_crc_en)
		begin
			r_crc <= '0;
			r_chk <= '0;
		end else begin
			r_crc <= nxt_crc;
			r_chk <= nxt_chk;
		end

		// Compare including the halves of the final cycle
		always_ff @(posedge i_clk)
		if (i_reset || !i_rx_en)
			r_bad <= 1'b0;
		else if (i_block_end && i_crc_en)
			r_bad <= rail_on && (nxt_crc != nxt_chk);

		assign	o_crc_bad[gk] = r_bad;
	end

	// Result strobe, one cycle after the last check half
	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en)
		o_crc_valid <= 1'b0;
	else
		o_crc_valid <= i_block_end && i_crc_en;

endmodule

`default_nettype wire

// ==== hw/sdrx_status.sv ====
`default_nettype none

module sdrx_status import sdrx_pkg::*; (
	input	wire			i_clk,
	input	wire			i_reset,
	input	wire			i_rx_en,
	input	wire	[1:0]		i_rx_strb,
	input	wire			i_busy,
	input	wire			i_crc_valid,
	input	wire	[NUMIO-1:0]	i_crc_bad,
	input	wire			i_block_end,
	output	logic			o_done,
	output	logic			o_err
);

	// Strobe-free cycles while busy
	logic	[LGTIMEOUT-1:0]	r_idle;
	logic			expire;
	// Block end delayed to line up with the CRC result
	logic			r_end_d;

	////////////////////////////////////////
	// Idle watchdog
	////////////////////////////////////////

	assign	expire = &r_idle;

	// Any strobe restarts the count, saturates once expired
	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en || !i_busy || (i_rx_strb != 2'b00))
		r_idle <= '0;
	else if (!expire)
		r_idle <= r_idle + 1'b1;

	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en)
		r_end_d <= 1'b0;
	else
		r_end_d <= i_block_end;

	////////////////////////////////////////
	// Done and error
	////////////////////////////////////////

	// Both hold until the enable drops
	always_ff @(posedge i_clk)
	if (i_reset || !i_rx_en)
	begin
		o_done <= 1'b0;
		o_err  <= 1'b0;
	end else if (!o_done)
	begin
		if (expire)
		begin
			// Stalled block
			o_done <= 1'b1;
			o_err  <= 1'b1;
		end else if (r_end_d)
		begin
			// CRC result is in this cycle when checking is on
			o_done <= 1'b1;
			o_err  <= i_crc_valid && (|i_crc_bad);
		end
	end

	a_err_done: assert property (@(posedge i_clk) disable iff (i_reset)
		o_err |-> o_done);

endmodule

`default_nettype wire

// ==== hw/sdrx_frame.sv ====
`default_nettype none

module sdrx_frame import sdrx_pkg::*; (
	input	wire			i_clk,
	input	wire			i_reset,
	input	wire			i_rx_en,
	input	wire			i_crc_en,
	input	wire			i_cfg_width,
	input	wire	[LGLEN:0]	i_length,
	input	wire	[1:0]		i_rx_strb,
	input	rxdata_t		i_rx_data,
	output	wire			o_mem_valid,
	output	wire	[NLANE-1:0]	o_mem_strb,
	output	wire	[LGLENW-1:0]	o_mem_addr,
	output	wire	[MW-1:0]	o_mem_data,
	output	wire			o_done,
	output	wire			o_err
);

	// Decode stage
	wire			data_hi, data_lo;
	wire			chk_hi, chk_lo;
	wire			busy, block_end;
	// Execute stage
	wire			byte_valid;
	byte_t			rx_byte;
	wire			crc_valid;
	wire	[NUMIO-1:0]	crc_bad;

	sdrx_phase phase_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_rx_en(i_rx_en),
		.i_cfg_width(i_cfg_width), .i_length(i_length), .i_rx_strb(i_rx_strb),
		.o_data_hi(data_hi), .o_data_lo(data_lo),
		.o_chk_hi(chk_hi), .o_chk_lo(chk_lo),
		.o_busy(busy), .o_block_end(block_end)
	);

	sdrx_bitpack bitpack_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_rx_en(i_rx_en),
		.i_cfg_width(i_cfg_width), .i_data_hi(data_hi), .i_data_lo(data_lo),
		.i_rx_data(i_rx_data), .o_byte_valid(byte_valid), .o_byte(rx_byte)
	);

	sdrx_memwrite memwrite_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_rx_en(i_rx_en),
		.i_byte_valid(byte_valid), .i_byte(rx_byte),
		.o_mem_valid(o_mem_valid), .o_mem_strb(o_mem_strb),
		.o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data)
	);

	sdrx_crcrail crcrail_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_rx_en(i_rx_en),
		.i_crc_en(i_crc_en), .i_cfg_width(i_cfg_width),
		.i_data_hi(data_hi), .i_data_lo(data_lo),
		.i_chk_hi(chk_hi), .i_chk_lo(chk_lo), .i_block_end(block_end),
		.i_rx_data(i_rx_data), .o_crc_valid(crc_valid), .o_crc_bad(crc_bad)
	);

	// Result stage
	sdrx_status status_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_rx_en(i_rx_en),
		.i_rx_strb(i_rx_strb), .i_busy(busy), .i_crc_valid(crc_valid),
		.i_crc_bad(crc_bad), .i_block_end(block_end),
		.o_done(o_done), .o_err(o_err)
	);

endmodule

`default_nettype wire

// ==== testbench/sdrx_tb.sv ====
`default_nettype none

module sdrx_tb import sdrx_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	// Five blocks, the longest is 64 bytes
	localparam int NUM_TESTS    = 5;
	localparam int MAX_LEN      = 64;
	localparam int WATCH_CYCLES = NUM_TESTS * (2 * MAX_LEN * 8 + 2100);
	// Room for the longest one-wire block plus check halves
	localparam int MAX_HALVES = 4200;
	localparam int NWORDS     = 1 << LGLENW;

	logic			i_clk;
	logic			i_reset;
	logic			i_rx_en;
	logic			i_crc_en;
	logic			i_cfg_width;
	logic	[LGLEN:0]	i_length;
	logic	[1:0]		i_rx_strb;
	rxdata_t		i_rx_data;
	wire			o_mem_valid;
	wire	[NLANE-1:0]	o_mem_strb;
	wire	[LGLENW-1:0]	o_mem_addr;
	wire	[MW-1:0]	o_mem_data;
	wire			o_done;
	wire			o_err;

	// Stimulus stream, one entry per sampled half, bit k is rail k
	logic	[3:0]		halves [0:MAX_HALVES-1];
	int			n_halves;
	int			n_data_halves;
	byte_t			exp_bytes [0:(1<<LGLEN)-1];
	// Scoreboard state
	logic	[MW-1:0]	mem_model [0:NWORDS-1];
	int			write_count;
	int			exp_writes;
	int			error_count = 0;
	logic	[31:0]		rng_state = 32'd84878;

	sdrx_frame dut_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_rx_en(i_rx_en),
		.i_crc_en(i_crc_en), .i_cfg_width(i_cfg_width), .i_length(i_length),
		.i_rx_strb(i_rx_strb), .i_rx_data(i_rx_data),
		.o_mem_valid(o_mem_valid), .o_mem_strb(o_mem_strb),
		.o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data),
		.o_done(o_done), .o_err(o_err)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD/2) i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic	[31:0]	x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Serial CRC16 of one rail over the data halves, zero seed, MSB first
	function automatic logic [15:0] rail_crc(input int rail, input int ndata);
		logic	[15:0]	crc;
		logic		fb;
		crc = 16'h0000;
		for (int h = 0; h < ndata; h++)
		begin
			fb  = crc[15] ^ halves[h][rail];
			crc = {crc[14:0], 1'b0} ^ ({16{fb}} & 16'h1021);
		end
		return crc;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
		begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, got, expected);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_run(input string why);
		error_count++;
		$display("ERROR at %0t ns: %s", $time, why);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	// Random bytes, then per-half bit streams and the check halves
	task automatic build_stream(input logic width, input int nbytes,
			input logic flip_rail2);
		logic	[15:0]	crc [0:NUMIO-1];
		byte_t		b;
		n_halves = 0;
		for (int j = 0; j < nbytes; j++)
		begin
			rng_state = xorshift32(rng_state);
			b = rng_state[15:8];
			exp_bytes[j] = b;
			if (width == WIDTH_4W)
			begin
				// High nibble goes out first
				halves[n_halves]   = b[7:4];
				halves[n_halves+1] = b[3:0];
				n_halves += 2;
			end else begin
				for (int k = 7; k >= 0; k--)
				begin
					halves[n_halves] = {3'b000, b[k]};
					n_halves++;
				end
			end
		end
		n_data_halves = n_halves;
		for (int k = 0; k < NUMIO; k++)
			crc[k] = rail_crc(k, n_data_halves);
		// Sixteen check halves, CRC MSB first on each rail
		for (int j = 0; j < CRC_W; j++)
		begin
			halves[n_halves] = 4'h0;
			for (int k = 0; k < NUMIO; k++)
				if (width == WIDTH_4W || k == 0)
					halves[n_halves][k] = crc[k][CRC_W-1-j];
			n_halves++;
		end
		// Corrupt one check bit of rail 2
		if (flip_rail2)
			halves[n_data_halves+5][2] = ~halves[n_data_halves+5][2];
	endtask

	task automatic wait_done(input int max_cycles);
		int	cycles;
		cycles = 0;
		do
		begin
			@(negedge i_clk);
			cycles++;
		end while (o_done !== 1'b1 && cycles < max_cycles);
		if (o_done !== 1'b1)
			fail_run("done did not rise within the allowed cycles");
	endtask

	// Send send_halves of the stream, then check result and memory
	task automatic run_block(input logic width, input int nbytes, input logic crc_on,
			input logic gaps, input int send_halves, input int max_wait,
			input logic exp_err);
		int		idx;
		int		bph;
		int		sent_data;
		logic	[1:0]	strb;
		rxdata_t	data;
		logic	[31:0]	expw;
		bph       = (width == WIDTH_4W) ? 4 : 1;
		sent_data = (send_halves < n_data_halves) ? send_halves : n_data_halves;
		exp_writes  = (sent_data * bph) / 8;
		write_count = 0;
		for (int w = 0; w < NWORDS; w++)
			mem_model[w] = '0;

		@(posedge i_clk);
		i_cfg_width <= width;
		i_length    <= (LGLEN+1)'(nbytes);
		i_crc_en    <= crc_on;
		i_rx_en     <= 1'b1;

		idx = 0;
		while (idx < send_halves)
		begin
			@(posedge i_clk);
			if (gaps)
			begin
				rng_state = xorshift32(rng_state);
				strb = rng_state[1:0];
			end else
				strb = 2'b11;
			data = '0;
			// First half is the older one
			if (strb[1] && idx < send_halves)
			begin
				data[11:8] = halves[idx];
				idx++;
			end else
				strb[1] = 1'b0;
			if (strb[0] && idx < send_halves)
			begin
				data[3:0] = halves[idx];
				idx++;
			end else
				strb[0] = 1'b0;
			i_rx_strb <= strb;
			i_rx_data <= data;
		end
		@(posedge i_clk);
		i_rx_strb <= 2'b00;
		i_rx_data <= '0;

		wait_done(max_wait);
		check_value("error flag at done", o_err, exp_err);
		check_value("bytes written", write_count, exp_writes);
		// Memory contents, big-endian lanes
		for (int w = 0; w < (exp_writes + NLANE - 1) / NLANE; w++)
		begin
			expw = '0;
			for (int l = 0; l < NLANE; l++)
				if (w*NLANE + l < exp_writes)
					expw[31-8*l -: 8] = exp_bytes[w*NLANE + l];
			check_value("memory word", mem_model[w], expw);
		end

		// Dropping the enable clears the outputs
		@(posedge i_clk);
		i_rx_en <= 1'b0;
		@(posedge i_clk);
		@(negedge i_clk);
		check_value("done after disable", o_done, 1'b0);
		check_value("error after disable", o_err, 1'b0);
		check_value("mem valid after disable", o_mem_valid, 1'b0);
		check_value("mem strobe after disable", o_mem_strb, 4'b0000);
	endtask

	////////////////////////////////////////
	// Write scoreboard
	////////////////////////////////////////

	always @(negedge i_clk)
	begin : compare_writes
		int	lane;
		if (!i_reset && o_mem_valid === 1'b1)
		begin
			if (write_count >= exp_writes)
				fail_run("memory write after the last expected byte");
			lane = write_count % NLANE;
			check_value("write address", o_mem_addr, write_count / NLANE);
			check_value("write strobe", o_mem_strb, 4'b1000 >> lane);
			check_value("write data", o_mem_data,
				{exp_bytes[write_count], 24'h000000} >> (8*lane));
			for (int l = 0; l < NLANE; l++)
				if (o_mem_strb[NLANE-1-l])
					mem_model[o_mem_addr][31-8*l -: 8] = o_mem_data[31-8*l -: 8];
			write_count++;
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		i_reset     <= 1'b1;
		i_rx_en     <= 1'b0;
		i_crc_en    <= 1'b0;
		i_cfg_width <= WIDTH_1W;
		i_length    <= '0;
		i_rx_strb   <= 2'b00;
		i_rx_data   <= '0;
		exp_writes  = 0;
		write_count = 0;
		repeat (8) @(posedge i_clk);
		i_reset <= 1'b0;
		@(posedge i_clk);
		@(negedge i_clk);
		check_value("mem valid after reset", o_mem_valid, 1'b0);
		check_value("mem strobe after reset", o_mem_strb, 4'b0000);
		check_value("done after reset", o_done, 1'b0);
		check_value("error after reset", o_err, 1'b0);

		// One wire, 32 bytes, steady strobes
		build_stream(WIDTH_1W, 32, 1'b0);
		run_block(WIDTH_1W, 32, 1'b1, 1'b0, n_halves, 10, 1'b0);

		// Four wires, 64 bytes, random strobe gaps
		build_stream(WIDTH_4W, 64, 1'b0);
		run_block(WIDTH_4W, 64, 1'b1, 1'b1, n_halves, 400, 1'b0);

		// Bad check bit on rail 2, then the same stream unchecked
		build_stream(WIDTH_4W, 16, 1'b1);
		run_block(WIDTH_4W, 16, 1'b1, 1'b0, n_halves, 10, 1'b1);
		run_block(WIDTH_4W, 16, 1'b0, 1'b0, n_halves, 10, 1'b0);

		// Strobes stop halfway through the data
		build_stream(WIDTH_4W, 16, 1'b0);
		run_block(WIDTH_4W, 16, 1'b1, 1'b0, n_data_halves / 2, 1030, 1'b1);

		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("ERROR: simulation ran past its time limit");
		$display("Test failed");
		$fatal(1, "time limit reached");
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/sdrx_pkg.sv
hw/sdrx_phase.sv
hw/sdrx_bitpack.sv
hw/sdrx_memwrite.sv
hw/sdrx_crcrail.sv
hw/sdrx_status.sv
hw/sdrx_frame.sv
testbench/sdrx_tb.sv
